/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcachePkg.sv
      - verilog/dcacheFsm.sv
      - verilog/dcacheArray.sv
      - verilog/dcacheTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/dcache_assert.sv
      - tb/dcacheTb.sv

/* tb.f */
+incdir+verilog
verilog/dcachePkg.sv
verilog/dcacheFsm.sv
verilog/dcacheArray.sv
verilog/dcacheTop.sv
tb/dcache_assert.sv
tb/dcacheTb.sv

/* tb/dcacheTb.sv */
/*
  testbench for the L1 data cache
  operations and expected results come from tb/dcache_golden.txt,
  so the run must start in the project root
  the bus memory answers after 1 to 4 cycles, seeded random delay
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcacheTb;

  localparam int Timeout  = 200;
  localparam int MaxRecs  = 32;
  localparam int MemWords = 1 << `DCACHE_ADDR_BITS;
  localparam int LineAdrBits = `DCACHE_TAG_BITS + `DCACHE_INDEX_BITS;
  // golden record: op, bus request count, address, data, line
  localparam int RecBits = 8 + `DCACHE_ADDR_BITS + `DCACHE_WORD_BITS + $bits(dcachePkg::lineT);

  logic                         clk;
  logic                         reset;
  dcachePkg::cpuReqT            cpuReq;
  logic                         flushCache;
  logic [`DCACHE_WORD_BITS-1:0] readData;
  logic                         cacheStall;
  dcachePkg::busReqT            busReq;
  logic                         busAck;
  dcachePkg::lineT              fetchLine;

  logic [RecBits-1:0]           golden [MaxRecs];
  logic [`DCACHE_WORD_BITS-1:0] mem [MemWords];
  logic [LineAdrBits-1:0]       wbAdrQ [$];
  dcachePkg::lineT              wbLineQ [$];
  int                           busOps;
  int                           errors;
  int                           tests;
  logic                         timedOut;

  always #5 clk = ~clk;

  dcacheTop dcacheTop_i (
    .clk        (clk),
    .reset      (reset),
    .cpuReq     (cpuReq),
    .flushCache (flushCache),
    .readData   (readData),
    .cacheStall (cacheStall),
    .busReq     (busReq),
    .busAck     (busAck),
    .fetchLine  (fetchLine)
  );

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic checkWord(input string name, input logic [`DCACHE_WORD_BITS-1:0] got,
                           input logic [`DCACHE_WORD_BITS-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkLine(input dcachePkg::lineT got, input logic [LineAdrBits-1:0] gotAdr,
                           input dcachePkg::lineT exp, input logic [LineAdrBits-1:0] expAdr);
    if (gotAdr !== expAdr) begin
      $display("MISMATCH at %0t: busReq.lineAdr got %h expected %h", $time, gotAdr, expAdr);
      errors++;
    end
    if (got !== exp) begin
      $display("MISMATCH at %0t: busReq.writeLine got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic checkIdle(input dcachePkg::busReqT req, input logic stall);
    tests++;
    if (req.rw !== 2'b00) begin
      $display("MISMATCH at %0t: busReq.rw got %b expected 00", $time, req.rw);
      errors++;
    end
    if (stall !== 1'b0) begin
      $display("MISMATCH at %0t: cacheStall got %b expected 0", $time, stall);
      errors++;
    end
    $display("test %0d: idle after reset, errors %0d", tests, errors);
  endtask

  task automatic checkBusOps(input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH at %0t: bus requests got %0d expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // bus memory model
  ////////////////////

  initial begin : busModel
    int a;
    int w;
    int delay;
    dcachePkg::busReqT req;
    busAck = 1'b0;
    fetchLine = '0;
    // each word holds its own address with a marker in the top byte
    for (a = 0; a < MemWords; a++) begin
      mem[a] = a + 32'hA500_0000;
    end
    delay = $urandom(37855);
    forever begin
      @(negedge clk);
      if (!reset && busReq.rw != 2'b00) begin
        req = busReq;
        busOps++;
        delay = $urandom % 4 + 1;
        repeat (delay) @(posedge clk);
        #1;
        for (w = 0; w < 4; w++) begin
          if (req.rw[0]) mem[{req.lineAdr, w[1:0]}] = req.writeLine[w];
          else fetchLine[w] = mem[{req.lineAdr, w[1:0]}];
        end
        if (req.rw[0]) begin
          wbAdrQ.push_back(req.lineAdr);
          wbLineQ.push_back(req.writeLine);
        end
        busAck = 1'b1;
        @(posedge clk);
        #1;
        busAck = 1'b0;
      end
    end
  end

  ////////////////////
  // CPU driver
  ////////////////////

  // writebacks left over belong to no golden record
  task automatic checkNoWriteback();
    while (wbAdrQ.size() != 0) begin
      $display("%0t: unexpected writeback of line %h", $time, wbAdrQ.pop_front());
      void'(wbLineQ.pop_front());
      errors++;
    end
  endtask

  task automatic runOp(input logic [3:0] op, input logic [3:0] nbus,
                       input logic [`DCACHE_ADDR_BITS-1:0] adr,
                       input logic [`DCACHE_WORD_BITS-1:0] data);
    int waitCnt;
    logic done;
    logic [`DCACHE_WORD_BITS-1:0] got;
    string name;
    checkNoWriteback();
    name = (op == 4'd1) ? "read" : (op == 4'd2) ? "write" : "flush";
    @(posedge clk);
    #1;
    busOps = 0;
    cpuReq.rw = (op == 4'd1) ? 2'b10 : (op == 4'd2) ? 2'b01 : 2'b00;
    cpuReq.addr.word = adr;
    cpuReq.writeData = data;
    flushCache = op == 4'd3;
    waitCnt = 0;
    done = 1'b0;
    // stall is stable from the falling edge to the next rising edge
    while (!done && waitCnt < Timeout) begin
      @(negedge clk);
      if (!cacheStall) done = 1'b1;
      else waitCnt++;
    end
    got = readData;
    @(posedge clk);
    #1;
    cpuReq.rw = 2'b00;
    flushCache = 1'b0;
    tests++;
    if (!done) begin
      $display("%0t: %s at %h never finished, cacheStall stayed high", $time, name, adr);
      errors++;
      timedOut = 1'b1;
    end else begin
      if (op == 4'd1) checkWord("readData", got, data);
      checkBusOps(busOps, nbus);
    end
    $display("test %0d: %s at %h, errors %0d", tests, name, adr, errors);
  endtask

  task automatic takeWriteback(input logic [LineAdrBits-1:0] expAdr,
                               input dcachePkg::lineT expLine);
    logic [LineAdrBits-1:0] gotAdr;
    dcachePkg::lineT gotLine;
    tests++;
    if (wbAdrQ.size() == 0) begin
      $display("%0t: expected writeback of line %h never came", $time, expAdr);
      errors++;
    end else begin
      gotAdr = wbAdrQ.pop_front();
      gotLine = wbLineQ.pop_front();
      checkLine(gotLine, gotAdr, expLine, expAdr);
    end
    $display("test %0d: writeback of line %h, errors %0d", tests, expAdr, errors);
  endtask

  initial begin : main
    int r;
    logic [3:0] op;
    logic [3:0] nbus;
    logic [`DCACHE_ADDR_BITS-1:0] adr;
    logic [`DCACHE_WORD_BITS-1:0] data;
    dcachePkg::lineT line;
    clk = 1'b0;
    reset = 1'b1;
    cpuReq = '0;
    flushCache = 1'b0;
    errors = 0;
    tests = 0;
    busOps = 0;
    timedOut = 1'b0;
    for (r = 0; r < MaxRecs; r++) begin
      golden[r] = '0;
    end
    $readmemh("tb/dcache_golden.txt", golden);
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    checkIdle(busReq, cacheStall);
    r = 0;
    // op 0 ends the list
    while (!timedOut && r < MaxRecs && golden[r][RecBits-1 -: 4] != 4'd0) begin
      {op, nbus, adr, data, line} = golden[r];
      if (op == 4'd4) takeWriteback(adr[LineAdrBits-1:0], line);
      else runOp(op, nbus, adr, data);
      r++;
    end
    checkNoWriteback();
    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/dcache_assert.sv */
/*
  bus and stall checks on the cache controller, attached by bind
  sampled on the rising clock edge, quiet while reset is high
*/
`timescale 1ns/1ps
`default_nettype none

module dcacheFsmAssert (
  input logic       clk,
  input logic       reset,
  input logic [1:0] busRw,
  input logic       busAck,
  input logic       cacheStall,
  input logic       flushCache,
  input logic [1:0] cpuRw,
  input logic       hit,
  input logic       ready
);

  // fetch and writeback never together
  busRwOneCmd: assert property (@(posedge clk) disable iff (reset) busRw != 2'b11)
    else $error("busRw asks for fetch and writeback at once");

  // a pending request stays put until its ack
  busRwHeld: assert property (@(posedge clk) disable iff (reset)
    (busRw != 2'b00 && !busAck) |=> busRw == $past(busRw))
    else $error("busRw changed before busAck");

  // hits and idle cycles never stall
  noIdleStall: assert property (@(posedge clk) disable iff (reset)
    (ready && !flushCache && (cpuRw == 2'b00 || hit)) |-> !cacheStall)
    else $error("cacheStall high in ready state without miss or flush");

endmodule

bind dcacheFsm dcacheFsmAssert fsmChk (
  .clk        (clk),
  .reset      (reset),
  .busRw      (busRw),
  .busAck     (busAck),
  .cacheStall (cacheStall),
  .flushCache (flushCache),
  .cpuRw      (cpuRw),
  .hit        (status.hit),
  .ready      (state == StReady)
);

`default_nettype wire

/* tb/dcache_golden.txt */
// columns op_bus_addr_data_line; op 1 read, 2 write, 3 flush, 4 expected writeback
// bus = request count of the op; read data = expected word; op 4 addr = line address
1_1_014_A5000014_00000000_00000000_00000000_00000000
1_0_016_A5000016_00000000_00000000_00000000_00000000
2_0_015_11112222_00000000_00000000_00000000_00000000
1_0_015_11112222_00000000_00000000_00000000_00000000
// conflicting tag in dirty set 5, old line goes out first
1_2_054_A5000054_00000000_00000000_00000000_00000000
4_0_005_00000000_A5000017_A5000016_11112222_A5000014
2_1_0A3_DEADBEEF_00000000_00000000_00000000_00000000
2_1_031_CAFE0001_00000000_00000000_00000000_00000000
// flush writes sets 8 and 12 only, then nothing on the second pass
3_2_000_00000000_00000000_00000000_00000000_00000000
4_0_028_00000000_DEADBEEF_A50000A2_A50000A1_A50000A0
4_0_00C_00000000_A5000033_A5000032_CAFE0001_A5000030
3_0_000_00000000_00000000_00000000_00000000_00000000
// evict set 8, then reread flushed and evicted data from memory
1_1_123_A5000123_00000000_00000000_00000000_00000000
1_1_0A3_DEADBEEF_00000000_00000000_00000000_00000000
1_1_015_11112222_00000000_00000000_00000000_00000000
1_0_031_CAFE0001_00000000_00000000_00000000_00000000

/* verilog/dcacheArray.sv */
/*
  tag, valid, dirty and line storage of the direct-mapped cache
  reads are combinational, writes land on the clock edge
  a fetched line is installed on the busAck edge while setValid is high
  only valid and dirty bits are cleared by reset
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcacheArray (
  input  logic                                            clk,
  input  logic                                            reset,
  input  dcachePkg::cpuReqT                               cpuReq,
  input  dcachePkg::arrayCtrlT                            ctrl,
  input  dcachePkg::lineT                                 fetchLine,
  input  logic                                            busAck,
  output dcachePkg::arrayStatusT                          status,
  output logic [`DCACHE_WORD_BITS-1:0]                    readData,
  output logic [`DCACHE_TAG_BITS+`DCACHE_INDEX_BITS-1:0]  busLine,
  output dcachePkg::lineT                                 busWriteLine
);

  localparam int Sets = 1 << `DCACHE_INDEX_BITS;

  logic [`DCACHE_TAG_BITS-1:0]   tagMem [Sets];
  dcachePkg::lineT               lineMem [Sets];
  logic [Sets-1:0]               validBits;
  logic [Sets-1:0]               dirtyBits;
  logic [`DCACHE_INDEX_BITS-1:0] flushCnt;
  logic [`DCACHE_INDEX_BITS-1:0] cpuIdx;
  logic [`DCACHE_INDEX_BITS-1:0] selIdx;
  dcachePkg::cacheAddrT          busAdr;
  dcachePkg::lineT               mergedLine;
  logic                          install;
  logic                          hitWrite;

  assign cpuIdx   = cpuReq.addr.f.index;
  // flush walks the sets by counter, everything else by CPU index
  assign selIdx   = ctrl.selFlush ? flushCnt : cpuIdx;
  assign install  = ctrl.setValid & busAck;
  assign hitWrite = ctrl.setDirty & ~ctrl.setValid;

  assign status.hit = validBits[cpuIdx] & (tagMem[cpuIdx] == cpuReq.addr.f.tag);
  assign status.lineDirty = validBits[selIdx] & dirtyBits[selIdx];
  assign status.flushAdrFlag = &flushCnt;
  assign readData = lineMem[cpuIdx][cpuReq.addr.f.offset];

  ////////////////////
  // bus address and line
  ////////////////////

  // victim and flush lines carry the stored tag, a fetch the CPU tag
  always_comb begin
    busAdr.f.tag = (ctrl.selWriteback | ctrl.selFlush) ? tagMem[selIdx] : cpuReq.addr.f.tag;
    busAdr.f.index = selIdx;
    busAdr.f.offset = '0;
  end
  assign busLine = busAdr.word[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS];
  assign busWriteLine = lineMem[selIdx];

  // write miss drops its word into the incoming line
  always_comb begin
    mergedLine = fetchLine;
    if (ctrl.setDirty) mergedLine[cpuReq.addr.f.offset] = cpuReq.writeData;
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (install) begin
      tagMem[cpuIdx] <= cpuReq.addr.f.tag;
      lineMem[cpuIdx] <= mergedLine;
    end else if (hitWrite) begin
      lineMem[cpuIdx][cpuReq.addr.f.offset] <= cpuReq.writeData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (install) begin
      validBits[cpuIdx] <= 1'b1;
      dirtyBits[cpuIdx] <= ctrl.setDirty;
    end else if (hitWrite) begin
      dirtyBits[cpuIdx] <= 1'b1;
    end else if (ctrl.clearDirty) begin
      dirtyBits[selIdx] <= 1'b0;
    end
  end

  // flush set counter, left at 0 between flushes
  always_ff @(posedge clk) begin
    if (reset | ctrl.flushCntRst) begin
      flushCnt <= '0;
    end else if (ctrl.flushAdrCntEn) begin
      flushCnt <= flushCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/dcacheFsm.sv */
/*
  miss, writeback and flush controller of the L1 data cache
  all outputs are combinational from state and inputs
  cpuRw and flushCache must be held until cacheStall is low at an edge
  bus requests are held through the busAck cycle, waits have no timeout
*/
`timescale 1ns/1ps
`default_nettype none

module dcacheFsm (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [1:0]             cpuRw,
  input  logic                   flushCache,
  input  logic                   busAck,
  input  dcachePkg::arrayStatusT status,
  output dcachePkg::arrayCtrlT   ctrl,
  output logic [1:0]             busRw,
  output logic                   cacheStall
);

  typedef enum logic [2:0] {
    StReady,
    StFetch,
    StEvict,
    StWriteLine,
    StReadDelay,
    StFlush,
    StFlushWb
  } stateT;

  stateT state, nextState;

  logic anyMiss;
  logic writeHit;
  logic lastSet;

  ////////////////////
  // request decode
  ////////////////////

  // flush wins over a CPU request in the ready state
  assign anyMiss  = ~flushCache & (|cpuRw) & ~status.hit;
  assign writeHit = ~flushCache & cpuRw[0] & status.hit;
  assign lastSet  = status.flushAdrFlag;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= StReady;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      StReady: begin
        if (flushCache) nextState = StFlush;
        // dirty victim goes out before the fetch
        else if (anyMiss & status.lineDirty) nextState = StEvict;
        else if (anyMiss) nextState = StFetch;
      end
      StFetch: begin
        if (busAck) nextState = StWriteLine;
      end
      StEvict: begin
        if (busAck) nextState = StFetch;
      end
      // a write is finished here, a read rereads the new line
      StWriteLine: begin
        nextState = cpuRw[0] ? StReady : StReadDelay;
      end
      StReadDelay: begin
        nextState = StReady;
      end
      StFlush: begin
        if (status.lineDirty) nextState = StFlushWb;
        else if (lastSet) nextState = StReady;
      end
      StFlushWb: begin
        if (busAck) nextState = lastSet ? StReady : StFlush;
      end
      default: begin
        nextState = StReady;
      end
    endcase
  end

  ////////////////////
  // CPU stall
  ////////////////////

  always_comb begin
    case (state)
      StReady:     cacheStall = flushCache | anyMiss;
      StFetch:     cacheStall = 1'b1;
      StEvict:     cacheStall = 1'b1;
      StWriteLine: cacheStall = ~cpuRw[0];
      StReadDelay: cacheStall = 1'b1;
      // released in the cycle that finishes the last set
      StFlush:     cacheStall = ~(lastSet & ~status.lineDirty);
      StFlushWb:   cacheStall = ~(lastSet & busAck);
      default:     cacheStall = 1'b1;
    endcase
  end

  ////////////////////
  // array strobes
  ////////////////////

  // install happens in the array on the busAck edge of a fetch
  assign ctrl.setValid = state == StFetch;
  // write hit, or write miss merging into the fetched line
  assign ctrl.setDirty = (state == StReady & writeHit) |
                         (state == StFetch & cpuRw[0]);
  assign ctrl.clearDirty = state == StFlushWb & busAck;
  assign ctrl.selWriteback = (state == StReady & anyMiss & status.lineDirty) |
                             (state == StEvict);
  assign ctrl.selFlush = (state == StFlush) | (state == StFlushWb);

  // step to the next set or wrap to 0 after the last one
  assign ctrl.flushAdrCntEn = ~lastSet & ((state == StFlush & ~status.lineDirty) |
                                          (state == StFlushWb & busAck));
  assign ctrl.flushCntRst = lastSet & ((state == StFlush & ~status.lineDirty) |
                                       (state == StFlushWb & busAck));

  ////////////////////
  // bus command
  ////////////////////

  // bit 1 fetch, bit 0 writeback, never both
  assign busRw[1] = (state == StReady & anyMiss & ~status.lineDirty) |
                    (state == StFetch);
  assign busRw[0] = (state == StReady & anyMiss & status.lineDirty) |
                    (state == StEvict) |
                    (state == StFlush & status.lineDirty) |
                    (state == StFlushWb);

endmodule

`default_nettype wire

/* verilog/dcachePkg.sv */
/*
  shared types of the L1 data cache
  rw encodings follow the CPU side: bit 1 read, bit 0 write
  on the bus side bit 1 is a line fetch, bit 0 a writeback
*/
`default_nettype none
`include "dcache_params.svh"

package dcachePkg;

  // one word address, seen flat or split into tag/index/offset
  typedef union packed {
    logic [`DCACHE_ADDR_BITS-1:0] word;
    struct packed {
      logic [`DCACHE_TAG_BITS-1:0]    tag;
      logic [`DCACHE_INDEX_BITS-1:0]  index;
      logic [`DCACHE_OFFSET_BITS-1:0] offset;
    } f;
  } cacheAddrT;

  // a whole cache line, word 0 in the low bits
  typedef logic [(1 << `DCACHE_OFFSET_BITS)-1:0][`DCACHE_WORD_BITS-1:0] lineT;

  typedef struct packed {
    logic [1:0]                   rw;
    cacheAddrT                    addr;
    logic [`DCACHE_WORD_BITS-1:0] writeData;
  } cpuReqT;

  typedef struct packed {
    logic [1:0]                                      rw;
    logic [`DCACHE_TAG_BITS+`DCACHE_INDEX_BITS-1:0]  lineAdr;
    lineT                                            writeLine;
  } busReqT;

  // array to controller
  typedef struct packed {
    logic hit;
    logic lineDirty;
    logic flushAdrFlag;
  } arrayStatusT;

  // controller to array
  typedef struct packed {
    logic setValid;
    logic setDirty;
    logic clearDirty;
    logic selWriteback;
    logic selFlush;
    logic flushAdrCntEn;
    logic flushCntRst;
  } arrayCtrlT;

endpackage

`default_nettype wire

/* verilog/dcacheTop.sv */
/*
  top level of the direct-mapped write-back L1 data cache
  CPU request and flushCache are levels held until cacheStall is low
  bus request is held until a one-cycle busAck, fetchLine valid with it
*/
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcacheTop (
  input  logic                         clk,
  input  logic                         reset,
  input  dcachePkg::cpuReqT            cpuReq,
  input  logic                         flushCache,
  output logic [`DCACHE_WORD_BITS-1:0] readData,
  output logic                         cacheStall,
  output dcachePkg::busReqT            busReq,
  input  logic                         busAck,
  input  dcachePkg::lineT              fetchLine
);

  dcachePkg::arrayStatusT                         status;
  dcachePkg::arrayCtrlT                           ctrl;
  logic [1:0]                                     busRw;
  logic [`DCACHE_TAG_BITS+`DCACHE_INDEX_BITS-1:0] busLine;
  dcachePkg::lineT                                busWriteLine;

  // controller
  dcacheFsm fsm (
    .clk        (clk),
    .reset      (reset),
    .cpuRw      (cpuReq.rw),
    .flushCache (flushCache),
    .busAck     (busAck),
    .status     (status),
    .ctrl       (ctrl),
    .busRw      (busRw),
    .cacheStall (cacheStall)
  );

  // storage and datapath
  dcacheArray array (
    .clk          (clk),
    .reset        (reset),
    .cpuReq       (cpuReq),
    .ctrl         (ctrl),
    .fetchLine    (fetchLine),
    .busAck       (busAck),
    .status       (status),
    .readData     (readData),
    .busLine      (busLine),
    .busWriteLine (busWriteLine)
  );

  // bus request bundle
  assign busReq.rw        = busRw;
  assign busReq.lineAdr   = busLine;
  assign busReq.writeLine = busWriteLine;

endmodule

`default_nettype wire

/* verilog/dcache_params.svh */
/*
  geometry of the direct-mapped L1 data cache
  addresses count words, not bytes
  tag + index + offset must add up to the address width
*/
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// data word width
`define DCACHE_WORD_BITS 32
// width of a word address
`define DCACHE_ADDR_BITS 12
// log2 of words per line
`define DCACHE_OFFSET_BITS 2
// log2 of sets
`define DCACHE_INDEX_BITS 4
// upper address bits kept in the tag store
`define DCACHE_TAG_BITS 6

`endif
